// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ptw
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "^PASS: all tests$$"

clean:
	rm -rf obj_dir

// ==== design/pte_check.sv ====
/*
 * PTE checker: classifies one fetched Sv32 PTE as a pointer to the
 * next table, a leaf that grants the access, or a page fault
 */
module pte_check (
  input  ptw_pkg::pte_t         pte_i,
  input  logic                  level_i,
  input  logic                  is_instr_i,
  input  logic                  is_store_i,
  input  logic                  mxr_i,
  output ptw_pkg::pte_verdict_e verdict_o
);

  logic invalid;
  logic is_leaf;
  logic last_level;
  logic misaligned;
  logic fetch_ok;
  logic load_ok;
  logic store_ok;
  logic perm_ok;

  // --------------------
  // encoding checks
  // --------------------
  // v clear, or the reserved write-only encoding
  assign invalid    = !pte_i.v || (!pte_i.r && pte_i.w);
  // r or x marks a leaf, otherwise a pointer
  assign is_leaf    = pte_i.r || pte_i.x;
  // a pointer here has nowhere left to go
  assign last_level = (level_i == 1'(ptw_pkg::PT_LEVELS - 1));
  // superpage leaf must have ppn[0] slice zero
  assign misaligned = (level_i == 1'b0) && (pte_i.ppn[ptw_pkg::VPN_W-1:0] != '0);

  // --------------------
  // permission checks
  // --------------------
  // accessed bit is software managed, so a clear a always faults
  assign fetch_ok = pte_i.x && pte_i.a;
  // mxr lets loads read execute-only pages
  assign load_ok  = pte_i.a && (pte_i.r || (pte_i.x && mxr_i));
  // store also needs write and dirty already set
  assign store_ok = load_ok && pte_i.w && pte_i.d;

  always_comb begin
    if (is_instr_i) begin
      perm_ok = fetch_ok;
    end else if (is_store_i) begin
      perm_ok = store_ok;
    end else begin
      perm_ok = load_ok;
    end
  end

  // misaligned superpage folds into the fault verdict
  always_comb begin
    if (invalid) begin
      verdict_o = ptw_pkg::PTE_FAULT;
    end else if (!is_leaf) begin
      verdict_o = last_level ? ptw_pkg::PTE_FAULT : ptw_pkg::PTE_POINTER;
    end else if (misaligned || !perm_ok) begin
      verdict_o = ptw_pkg::PTE_FAULT;
    end else begin
      verdict_o = ptw_pkg::PTE_LEAF_OK;
    end
  end

endmodule

// ==== design/ptw_fsm.sv ====
/*
 * Sv32 walk state machine: accepts a TLB miss, issues up to two PTE reads,
 * follows pointers and emits one TLB update or one page-fault pulse
 */
module ptw_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  ptw_pkg::ptw_miss_t          miss_i,
  input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn_i,
  input  ptw_pkg::mem_rsp_t           mem_rsp_i,
  input  ptw_pkg::pte_verdict_e       verdict_i,
  output ptw_pkg::mem_req_t           mem_req_o,
  output ptw_pkg::pte_t               pte_o,
  output logic                        level_o,
  output logic                        is_instr_o,
  output logic                        is_store_o,
  output ptw_pkg::tlb_update_t        tlb_update_o,
  output logic                        error_o,
  output logic                        busy_o
);

  ptw_pkg::ptw_state_e state_q, state_d;

  // walk control
  logic level_q, level_d;
  logic is_instr_q, is_instr_d;
  logic is_store_q, is_store_d;
  // any PTE seen on this walk had g set
  logic global_q, global_d;

  // walk payload
  logic [ptw_pkg::PLEN-1:0]                     pptr_q, pptr_d;
  logic [ptw_pkg::VLEN-ptw_pkg::PAGE_OFS_W-1:0] vpn_q, vpn_d;
  logic [ptw_pkg::ASID_W-1:0]                   asid_q, asid_d;

  // registered memory response
  logic                      rvalid_q;
  logic [ptw_pkg::PTE_W-1:0] rdata_q;
  ptw_pkg::pte_t             pte_q;
  ptw_pkg::pte_t             leaf_pte;

  logic update_valid;

  assign pte_q = ptw_pkg::pte_t'(rdata_q);

  // --------------------
  // outputs to the checker and the memory
  // --------------------
  assign pte_o      = pte_q;
  assign level_o    = level_q;
  assign is_instr_o = is_instr_q;
  assign is_store_o = is_store_q;

  // request follows the state and drops once the grant edge moves us on
  assign mem_req_o.req  = (state_q == ptw_pkg::WAIT_GRANT);
  assign mem_req_o.addr = pptr_q;

  assign busy_o = (state_q != ptw_pkg::IDLE);

  // --------------------
  // TLB update
  // --------------------
  // leaf content carries the global bit collected on the way down
  always_comb begin
    leaf_pte   = pte_q;
    leaf_pte.g = pte_q.g | global_q;
  end

  assign tlb_update_o.valid        = update_valid;
  assign tlb_update_o.vpn          = vpn_q;
  assign tlb_update_o.asid         = asid_q;
  // a leaf at the top table maps 4 MiB
  assign tlb_update_o.is_superpage = (level_q == 1'b0);
  assign tlb_update_o.content      = leaf_pte;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    state_d      = state_q;
    level_d      = level_q;
    is_instr_d   = is_instr_q;
    is_store_d   = is_store_q;
    global_d     = global_q;
    pptr_d       = pptr_q;
    vpn_d        = vpn_q;
    asid_d       = asid_q;
    update_valid = 1'b0;
    error_o      = 1'b0;

    case (state_q)
      ptw_pkg::IDLE: begin
        if (miss_i.valid) begin
          level_d    = 1'b0;
          global_d   = 1'b0;
          is_instr_d = miss_i.is_instr;
          is_store_d = miss_i.is_store;
          vpn_d      = miss_i.vaddr[ptw_pkg::VLEN-1:ptw_pkg::PAGE_OFS_W];
          asid_d     = miss_i.asid;
          // root table from satp indexed by vpn[1] with 4-byte PTEs
          pptr_d     = {satp_ppn_i,
                        miss_i.vaddr[ptw_pkg::VLEN-1 -: ptw_pkg::VPN_W],
                        2'b00};
          state_d    = ptw_pkg::WAIT_GRANT;
        end
      end

      ptw_pkg::WAIT_GRANT: begin
        if (mem_rsp_i.gnt) begin
          state_d = ptw_pkg::PTE_LOOKUP;
        end
      end

      ptw_pkg::PTE_LOOKUP: begin
        // checker verdict is only meaningful with the registered rvalid
        if (rvalid_q) begin
          if (pte_q.g) begin
            global_d = 1'b1;
          end
          case (verdict_i)
            ptw_pkg::PTE_POINTER: begin
              // next table from the PTE indexed by vpn[0]
              level_d = level_q + 1'b1;
              pptr_d  = {pte_q.ppn, vpn_q[ptw_pkg::VPN_W-1:0], 2'b00};
              state_d = ptw_pkg::WAIT_GRANT;
            end
            ptw_pkg::PTE_LEAF_OK: begin
              update_valid = 1'b1;
              state_d      = ptw_pkg::LATENCY;
            end
            default: begin
              state_d = ptw_pkg::PROPAGATE_ERROR;
            end
          endcase
        end
      end

      ptw_pkg::PROPAGATE_ERROR: begin
        error_o = 1'b1;
        state_d = ptw_pkg::LATENCY;
      end

      // only reached after a flush with a read in flight
      ptw_pkg::WAIT_RVALID: begin
        if (rvalid_q) begin
          state_d = ptw_pkg::IDLE;
        end
      end

      ptw_pkg::LATENCY: begin
        state_d = ptw_pkg::IDLE;
      end

      default: begin
        state_d = ptw_pkg::IDLE;
      end
    endcase

    // --------------------
    // flush
    // --------------------
    // kill any pulse and drain an outstanding read before going idle
    if (flush_i) begin
      update_valid = 1'b0;
      error_o      = 1'b0;
      if (((state_q == ptw_pkg::WAIT_GRANT) && mem_rsp_i.gnt) ||
          ((state_q inside {ptw_pkg::PTE_LOOKUP, ptw_pkg::WAIT_RVALID}) && !rvalid_q)) begin
        state_d = ptw_pkg::WAIT_RVALID;
      end else begin
        state_d = ptw_pkg::LATENCY;
      end
    end
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ptw_pkg::IDLE;
      level_q    <= 1'b0;
      is_instr_q <= 1'b0;
      is_store_q <= 1'b0;
      global_q   <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      level_q    <= level_d;
      is_instr_q <= is_instr_d;
      is_store_q <= is_store_d;
      global_q   <= global_d;
      rvalid_q   <= mem_rsp_i.rvalid;
    end
  end

  // walk payload and the last read data
  always_ff @(posedge clk_i) begin
    pptr_q <= pptr_d;
    vpn_q  <= vpn_d;
    asid_q <= asid_d;
    if (mem_rsp_i.rvalid) begin
      rdata_q <= mem_rsp_i.rdata;
    end
  end

endmodule

// ==== design/ptw_pkg.sv ====
/*
 * Sv32 page-table walker shared definitions
 * address widths, PTE layout, miss/memory/TLB-update records and state encodings
 */
package ptw_pkg;

  // --------------------
  // Sv32 geometry
  // --------------------
  // virtual address width
  localparam int unsigned VLEN       = 32;
  // physical address width, 22-bit ppn plus 12-bit offset
  localparam int unsigned PLEN       = 34;
  localparam int unsigned PPN_W      = 22;
  // each of the two vpn slices
  localparam int unsigned VPN_W      = 10;
  localparam int unsigned PT_LEVELS  = 2;
  localparam int unsigned ASID_W     = 9;
  localparam int unsigned PTE_W      = 32;
  localparam int unsigned PAGE_OFS_W = 12;

  // --------------------
  // PTE format
  // --------------------
  // msb first, matches the architectural bit order
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  // --------------------
  // port records
  // --------------------
  // miss from the TLB, valid held until busy rises
  typedef struct packed {
    logic              valid;
    logic [VLEN-1:0]   vaddr;
    logic              is_instr;
    logic              is_store;
    logic [ASID_W-1:0] asid;
  } ptw_miss_t;

  // walker to memory, word-aligned read only
  typedef struct packed {
    logic            req;
    logic [PLEN-1:0] addr;
  } mem_req_t;

  // memory to walker
  typedef struct packed {
    logic             gnt;
    logic             rvalid;
    logic [PTE_W-1:0] rdata;
  } mem_rsp_t;

  // one-cycle refill for the TLB
  typedef struct packed {
    logic                       valid;
    logic [VLEN-PAGE_OFS_W-1:0] vpn;
    logic [ASID_W-1:0]          asid;
    // 4 MiB mapping found at the top level
    logic                       is_superpage;
    pte_t                       content;
  } tlb_update_t;

  // --------------------
  // encodings
  // --------------------
  typedef enum logic [1:0] {
    PTE_POINTER,
    PTE_LEAF_OK,
    PTE_FAULT
  } pte_verdict_e;

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR,
    LATENCY
  } ptw_state_e;

endpackage

// ==== design/ptw_top.sv ====
/*
 * Sv32 page-table walker top: walk state machine plus PTE checker
 */
module ptw_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  ptw_pkg::ptw_miss_t        miss_i,
  input  logic [ptw_pkg::PPN_W-1:0] satp_ppn_i,
  input  logic                      mxr_i,
  input  ptw_pkg::mem_rsp_t         mem_rsp_i,
  output ptw_pkg::mem_req_t         mem_req_o,
  output ptw_pkg::tlb_update_t      tlb_update_o,
  output logic                      error_o,
  output logic                      busy_o
);

  // --------------------
  // fsm to checker
  // --------------------
  ptw_pkg::pte_t         pte;
  logic                  level;
  logic                  is_instr;
  logic                  is_store;
  ptw_pkg::pte_verdict_e verdict;

  ptw_fsm u_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .miss_i       (miss_i),
    .satp_ppn_i   (satp_ppn_i),
    .mem_rsp_i    (mem_rsp_i),
    .verdict_i    (verdict),
    .mem_req_o    (mem_req_o),
    .pte_o        (pte),
    .level_o      (level),
    .is_instr_o   (is_instr),
    .is_store_o   (is_store),
    .tlb_update_o (tlb_update_o),
    .error_o      (error_o),
    .busy_o       (busy_o)
  );

  // mxr goes straight to the checker, the fsm never looks at it
  pte_check u_check (
    .pte_i      (pte),
    .level_i    (level),
    .is_instr_i (is_instr),
    .is_store_i (is_store),
    .mxr_i      (mxr_i),
    .verdict_o  (verdict)
  );

endmodule

// ==== sources.f ====
design/ptw_pkg.sv
design/pte_check.sv
design/ptw_fsm.sv
design/ptw_top.sv
tb/tb_clock.sv
tb/tb_mem_model.sv
tb/ptw_sva.sv
tb/tb_ptw.sv

// ==== tb/ptw_sva.sv ====
/*
 * walker handshake assertions, bound into the walk state machine
 */
module ptw_sva (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                flush_i,
  input ptw_pkg::mem_req_t   mem_req_i,
  input ptw_pkg::mem_rsp_t   mem_rsp_i,
  input ptw_pkg::tlb_update_t update_i,
  input logic                error_i,
  input logic                busy_i,
  input ptw_pkg::ptw_state_e state_i
);

  // request held with a stable address until granted unless a flush drops it
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_i.req && !mem_rsp_i.gnt && !flush_i |=> mem_req_i.req && $stable(mem_req_i.addr))
    else $error("memory request dropped or address changed before grant");

  // a walk ends in exactly one kind of pulse
  a_one_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(update_i.valid && error_i))
    else $error("tlb update and page fault in the same cycle");

  // busy falls and the walker sits in IDLE two cycles after its result pulse
  a_idle_after_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $past(update_i.valid || error_i, 2) && !$past(flush_i) |->
      $fell(busy_i) && (state_i == ptw_pkg::IDLE))
    else $error("walker not back in idle two cycles after its result");

endmodule

bind ptw_fsm ptw_sva u_sva (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .flush_i   (flush_i),
  .mem_req_i (mem_req_o),
  .mem_rsp_i (mem_rsp_i),
  .update_i  (tlb_update_o),
  .error_i   (error_o),
  .busy_i    (busy_o),
  .state_i   (state_q)
);

// ==== tb/ptw_tests.txt ====
# m <word addr> <pte>     all hex
# t <satp_ppn> <mxr> <vaddr> <kind 0 ld 1 st 2 fetch> <asid> <flush cycle> <exp 0 none 1 update 2 fault> <superpage> <ppn> <g>
m 00004001 00008001
m 00008001 048d14c7
m 00004002 0010004b
m 00004003 00008421
m 00008402 002af043
m 00008003 000ccc87
m 00008004 00111047
m 00008005 00155449
m 00004004 0000000e
m 00004005 00000005
m 00008006 00008001
m 00004006 00100443
t 010 0 00401abc 0 005 0 1 0 12345 0
t 010 0 00800000 2 006 0 1 1 00400 0
t 010 0 00c02000 0 007 0 1 0 00abc 1
t 010 0 00401000 2 001 0 2 0 0 0
t 010 0 00403000 0 001 0 2 0 0 0
t 010 0 00404000 1 001 0 2 0 0 0
t 010 0 00405000 0 001 0 2 0 0 0
t 010 1 00405000 0 002 0 1 0 00555 0
t 010 0 01000000 0 003 0 2 0 0 0
t 010 0 01400000 0 003 0 2 0 0 0
t 010 0 00406000 0 003 0 2 0 0 0
t 010 0 01800000 0 003 0 2 0 0 0
t 010 0 00401abc 0 004 2 0 0 0 0
t 010 0 00401abc 1 1ff 0 1 0 12345 0

// ==== tb/tb_clock.sv ====
/*
 * testbench clock source, period 4
 */
module tb_clock (
  output logic clk_o
);

  // start low so the first rising edge lands at time 2
  initial clk_o = 1'b0;

  always #2 clk_o = ~clk_o;

endmodule

// ==== tb/tb_mem_model.sv ====
/*
 * page-table memory for the walker testbench
 * grants after a random 0..3 cycle delay, read data one cycle after the grant
 */
module tb_mem_model (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  ptw_pkg::mem_req_t mem_req_i,
  output ptw_pkg::mem_rsp_t mem_rsp_o
);

  // sparse word store where unwritten words read as an address pattern with v clear
  logic [31:0] mem [logic [31:0]];

  logic        armed;
  logic [1:0]  cnt;
  logic [31:0] lfsr_q;
  logic        b0;
  logic        b1;
  logic        gnt;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  // galois step for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] waddr);
    if (mem.exists(waddr)) begin
      return mem[waddr];
    end else begin
      return {waddr[31:1] ^ waddr[30:0], 1'b0};
    end
  endfunction

  // loaded from the testbench top while parsing the tests file
  task automatic write_word(input logic [31:0] waddr, input logic [31:0] data);
    mem[waddr] = data;
  endtask

  // grant once the delay counter has run out
  assign gnt       = mem_req_i.req && armed && (cnt == 2'd0);
  assign mem_rsp_o = '{gnt: gnt, rvalid: rvalid_q, rdata: rdata_q};

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      armed    <= 1'b0;
      cnt      <= 2'd0;
      rvalid_q <= 1'b0;
      rdata_q  <= 32'h0;
      lfsr_q = 32'hf3e68253;
    end else begin
      rvalid_q <= gnt;
      if (gnt) begin
        rdata_q <= read_word(mem_req_i.addr[ptw_pkg::PLEN-1:2]);
      end
      // dropped request (flush) cancels the pending grant
      if (!mem_req_i.req) begin
        armed <= 1'b0;
      end else if (!armed) begin
        // one lfsr step for each of the two delay bits
        b0 = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        b1 = lfsr_q[0];
        lfsr_q = lfsr_next(lfsr_q);
        armed <= 1'b1;
        cnt   <= {b1, b0};
      end else if (cnt != 2'd0) begin
        cnt <= cnt - 2'd1;
      end else begin
        armed <= 1'b0;
      end
    end
  end

endmodule

// ==== tb/tb_ptw.sv ====
/*
 * Sv32 walker testbench: loads page tables and tests from the tests file,
 * drives one miss per test and checks the update or fault pulse
 */
module tb_ptw;

  localparam int MAX_TESTS = 32;

  logic                      clk_i;
  logic                      rst_ni;
  logic                      flush_i;
  ptw_pkg::ptw_miss_t        miss_i;
  logic [ptw_pkg::PPN_W-1:0] satp_ppn_i;
  logic                      mxr_i;
  ptw_pkg::mem_req_t         mem_req;
  ptw_pkg::mem_rsp_t         mem_rsp;
  ptw_pkg::tlb_update_t      tlb_update;
  logic                      error;
  logic                      busy;

  // --------------------
  // test table
  // --------------------
  logic [21:0] t_satp  [MAX_TESTS];
  logic        t_mxr   [MAX_TESTS];
  logic [31:0] t_vaddr [MAX_TESTS];
  // kind 0 load, 1 store, 2 fetch; exp 0 none, 1 update, 2 fault
  logic [1:0]  t_kind  [MAX_TESTS];
  logic [8:0]  t_asid  [MAX_TESTS];
  int          t_flush [MAX_TESTS];
  logic [1:0]  t_exp   [MAX_TESTS];
  logic        t_sp    [MAX_TESTS];
  logic [21:0] t_ppn   [MAX_TESTS];
  logic        t_g     [MAX_TESTS];

  int n_tests    = 0;
  int value_errs = 0;
  int pulse_errs = 0;
  int setup_errs = 0;
  int cycles     = 0;
  int limit      = 0;

  tb_clock u_clk (.clk_o(clk_i));

  tb_mem_model u_mem (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .mem_req_i (mem_req),
    .mem_rsp_o (mem_rsp)
  );

  ptw_top dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (flush_i),
    .miss_i       (miss_i),
    .satp_ppn_i   (satp_ppn_i),
    .mxr_i        (mxr_i),
    .mem_rsp_i    (mem_rsp),
    .mem_req_o    (mem_req),
    .tlb_update_o (tlb_update),
    .error_o      (error),
    .busy_o       (busy)
  );

  // run limit of 40 cycles per test plus 50
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (limit != 0 && cycles > limit) begin
      $display("timeout: walks did not finish within %0d cycles", limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  task automatic compare_value(input int idx, input string name,
                               input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] test %0d %s got %h exp %h", idx, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    string       line;
    logic [31:0] a [10];
    fd = $fopen("tb/ptw_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/ptw_tests.txt");
      setup_errs++;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (line.len() > 0 && line.getc(0) == "m") begin
          code = $sscanf(line, "m %h %h", a[0], a[1]);
          u_mem.write_word(a[0], a[1]);
        end else if (line.len() > 0 && line.getc(0) == "t" && n_tests < MAX_TESTS) begin
          code = $sscanf(line, "t %h %h %h %h %h %h %h %h %h %h",
                         a[0], a[1], a[2], a[3], a[4], a[5], a[6], a[7], a[8], a[9]);
          t_satp[n_tests]  = a[0][21:0];
          t_mxr[n_tests]   = a[1][0];
          t_vaddr[n_tests] = a[2];
          t_kind[n_tests]  = a[3][1:0];
          t_asid[n_tests]  = a[4][8:0];
          t_flush[n_tests] = int'(a[5]);
          t_exp[n_tests]   = a[6][1:0];
          t_sp[n_tests]    = a[7][0];
          t_ppn[n_tests]   = a[8][21:0];
          t_g[n_tests]     = a[9][0];
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_test(input int idx);
    int                   n_upd;
    int                   n_err;
    int                   cyc;
    ptw_pkg::tlb_update_t upd;
    ptw_pkg::pte_t        leaf;
    ptw_pkg::pte_t        exp_content;
    n_upd       = 0;
    n_err       = 0;
    cyc         = 0;
    upd         = '0;
    leaf        = '0;
    exp_content = '0;
    @(posedge clk_i);
    #1;
    flush_i         = 1'b0;
    satp_ppn_i      = t_satp[idx];
    mxr_i           = t_mxr[idx];
    miss_i.valid    = 1'b1;
    miss_i.vaddr    = t_vaddr[idx];
    miss_i.is_instr = (t_kind[idx] == 2'd2);
    miss_i.is_store = (t_kind[idx] == 2'd1);
    miss_i.asid     = t_asid[idx];
    // hold the miss until the walker takes it
    @(negedge clk_i);
    while (!busy) @(negedge clk_i);
    while (busy) begin
      @(posedge clk_i);
      #1;
      miss_i.valid = 1'b0;
      cyc++;
      flush_i = (t_flush[idx] != 0) && (cyc == t_flush[idx]);
      // sample mid-cycle
      @(negedge clk_i);
      // the last word the memory returns on a walk is the leaf
      if (mem_rsp.rvalid) begin
        leaf = ptw_pkg::pte_t'(mem_rsp.rdata);
      end
      if (tlb_update.valid) begin
        n_upd++;
        upd = tlb_update;
      end
      if (error) n_err++;
    end
    if (t_exp[idx] == 2'd1) begin
      if (n_upd != 1 || n_err != 0) begin
        $display("test %0d expected one tlb update, saw %0d updates and %0d faults",
                 idx, n_upd, n_err);
        pulse_errs++;
      end else begin
        // leaf as stored in the page table, g as the test line gives it
        exp_content   = leaf;
        exp_content.g = t_g[idx];
        compare_value(idx, "tlb_update_o.vpn", 32'(upd.vpn), 32'(t_vaddr[idx][31:12]));
        compare_value(idx, "tlb_update_o.asid", 32'(upd.asid), 32'(t_asid[idx]));
        compare_value(idx, "tlb_update_o.is_superpage", 32'(upd.is_superpage), 32'(t_sp[idx]));
        compare_value(idx, "tlb_update_o.content.ppn", 32'(upd.content.ppn), 32'(t_ppn[idx]));
        compare_value(idx, "tlb_update_o.content", 32'(upd.content), 32'(exp_content));
      end
    end else if (t_exp[idx] == 2'd2) begin
      if (n_err != 1 || n_upd != 0) begin
        $display("test %0d expected one page fault, saw %0d faults and %0d updates",
                 idx, n_err, n_upd);
        pulse_errs++;
      end
    end else begin
      if (n_upd != 0 || n_err != 0) begin
        $display("test %0d expected no result after flush, saw %0d updates and %0d faults",
                 idx, n_upd, n_err);
        pulse_errs++;
      end
    end
  endtask

  initial begin
    rst_ni     = 1'b0;
    flush_i    = 1'b0;
    miss_i     = '0;
    satp_ppn_i = '0;
    mxr_i      = 1'b0;
    load_tests();
    if (n_tests == 0) begin
      $display("no tests found in the tests file");
      setup_errs++;
    end
    limit = 40 * n_tests + 50;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int i = 0; i < n_tests; i++) begin
      run_test(i);
    end
    $display("errors: %0d value, %0d pulse, %0d setup", value_errs, pulse_errs, setup_errs);
    if (value_errs + pulse_errs + setup_errs == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
